/* all.f */
+incdir+include
verilog/fm_pkg.sv
verilog/timer_ctrl_if.sv
verilog/host_bus.sv
verilog/fm_regs.sv
verilog/fm_timers.sv
verilog/fm_lfo.sv
verilog/fm_tone.sv
verilog/fm_core.sv
verification/tb_fm_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fm_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verification/tb_fm_core.sv */
`timescale 1ns/1ps
`include "fm_params.svh"

module tb_fm_core;
	logic        clk_int;
	logic        rst;
	logic [7:0]  din;
	logic [1:0]  addr;
	logic        cs_n;
	logic        wr_n;
	logic [7:0]  dout;
	logic [11:0] snd;
	logic        sample;
	logic        irq_n;
	logic [31:0] rng;

	fm_core fm_core_inst (
		.clk_int(clk_int), .rst(rst), .din(din), .addr(addr), .cs_n(cs_n), .wr_n(wr_n),
		.dout(dout), .snd(snd), .sample(sample), .irq_n(irq_n)
	);

	initial begin
		clk_int = 1'b0;
		forever #2 clk_int = ~clk_int;
	end

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// Status bits 6..2 are always zero
	assert property (@(posedge clk_int) disable iff (rst) dout[6:2] == 5'b00000)
		else begin
			$display("[FAIL] dout[6:2] got 0x%0h expected 0x0", $sampled(dout[6:2]));
			stop_with_failure();
		end

	assert property (@(posedge clk_int) disable iff (rst) sample |=> !sample)
		else begin
			$display("sample stayed high for more than one cycle");
			stop_with_failure();
		end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_range(input string name, input int got, input int lo, input int hi);
		assert (got >= lo && got <= hi) else begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h..0x%0h", name, got, lo, hi);
			stop_with_failure();
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// One bus cycle, port 0 is the address latch and port 1 the data
	task automatic host_write(input logic port, input logic [7:0] data);
		@(posedge clk_int);
		#1;
		cs_n = 1'b0;
		wr_n = 1'b0;
		addr = {1'b0, port};
		din = data;
		@(posedge clk_int);
		#1;
		cs_n = 1'b1;
		wr_n = 1'b1;
	endtask

	task automatic reg_write(input fm_pkg::reg_addr_e ra, input logic [7:0] data);
		host_write(1'b0, 8'(ra));
		host_write(1'b1, data);
	endtask

	task automatic wait_sample(input int limit);
		int n;
		n = 0;
		@(negedge clk_int);
		while (!sample && n < limit) begin
			@(negedge clk_int);
			n++;
		end
		assert (sample) else begin
			$display("no sample pulse within %0d cycles", limit);
			stop_with_failure();
		end
	endtask

	task automatic wait_status(input int idx, input logic level, input int limit,
			input string what);
		int n;
		n = 0;
		@(negedge clk_int);
		while (dout[idx] !== level && n < limit) begin
			@(negedge clk_int);
			n++;
		end
		assert (dout[idx] === level) else begin
			$display("%s did not reach %0d within %0d cycles", what, level, limit);
			stop_with_failure();
		end
	endtask

	initial begin
		int          n;
		int          k;
		int          bound;
		int          lo;
		int          hi;
		logic [10:0] fnum;
		logic [10:0] lfo_base;
		logic [2:0]  block;
		logic [19:0] phase;
		logic [19:0] step;
		logic [9:0]  ta_val;
		logic [7:0]  tb_val;

		rst = 1'b1;
		din = 8'h00;
		addr = 2'b00;
		cs_n = 1'b1;
		wr_n = 1'b1;
		rng = 32'd75;
		repeat (5) @(posedge clk_int);
		#1;
		rst = 1'b0;

		@(negedge clk_int);
		check_value("irq_n", 32'(irq_n), 32'h1);
		check_value("sample", 32'(sample), 32'h0);
		check_value("dout", 32'(dout), 32'h0);

		// Busy window after one data write
		reg_write(fm_pkg::REG_TB, 8'h00);
		@(negedge clk_int);
		check_value("dout[7]", 32'(dout[7]), 32'h1);
		n = 1;
		@(negedge clk_int);
		while (dout[7] && n < 4 * `FM_BUSY_CYCLES) begin
			n++;
			@(negedge clk_int);
		end
		check_value("busy cycles", 32'(n), 32'(`FM_BUSY_CYCLES));

		// Sawtooth with random pitch and LFO off
		rng = xorshift(rng);
		fnum = rng[10:0];
		block = rng[13:11];
		step = 20'(fnum) << block;
		reg_write(fm_pkg::REG_FNUM_LO, fnum[7:0]);
		reg_write(fm_pkg::REG_FNUM_HI, {2'b00, block, fnum[10:8]});
		// Key on right after a frame so the next zero sees it
		wait_sample(2 * `FM_SLOTS);
		reg_write(fm_pkg::REG_KEY, 8'h10);
		phase = '0;
		repeat (16) begin
			wait_sample(2 * `FM_SLOTS);
			phase = phase + step;
			check_value("snd", 32'(snd), 32'(phase[19:8]));
		end

		// Timer A a few counts below overflow
		rng = xorshift(rng);
		k = 2 + int'(rng % 32'd7);
		ta_val = 10'(1024 - k);
		reg_write(fm_pkg::REG_TA_HI, ta_val[9:2]);
		reg_write(fm_pkg::REG_TA_LO, {6'b000000, ta_val[1:0]});
		reg_write(fm_pkg::REG_TIMER_CTL, 8'h05);
		wait_status(0, 1'b1, k * `FM_SLOTS + 60, "flag_a");
		check_value("irq_n", 32'(irq_n), 32'h0);
		// Clear with the enable kept so only the clear can release irq_n
		reg_write(fm_pkg::REG_TIMER_CTL, 8'h14);
		wait_status(0, 1'b0, 10, "flag_a");
		check_value("irq_n", 32'(irq_n), 32'h1);

		// Timer B runs with its enable clear, then enabled
		rng = xorshift(rng);
		k = int'(rng % 32'd3);
		tb_val = 8'(255 - k);
		bound = (k + 1) * `FM_TB_PRESCALE * `FM_SLOTS + 100;
		reg_write(fm_pkg::REG_TB, tb_val);
		reg_write(fm_pkg::REG_TIMER_CTL, 8'h02);
		repeat (bound) begin
			@(negedge clk_int);
			check_value("dout[1]", 32'(dout[1]), 32'h0);
			check_value("irq_n", 32'(irq_n), 32'h1);
		end
		reg_write(fm_pkg::REG_TIMER_CTL, 8'h0A);
		wait_status(1, 1'b1, bound, "flag_b");
		check_value("irq_n", 32'(irq_n), 32'h0);
		reg_write(fm_pkg::REG_TIMER_CTL, 8'h28);
		wait_status(1, 1'b0, 10, "flag_b");
		check_value("irq_n", 32'(irq_n), 32'h1);

		// Vibrato at the fastest LFO rate, block 0 keeps the phase from wrapping
		rng = xorshift(rng);
		lfo_base = 11'(256 + int'(rng[9:0]));
		reg_write(fm_pkg::REG_KEY, 8'h00);
		reg_write(fm_pkg::REG_FNUM_LO, lfo_base[7:0]);
		reg_write(fm_pkg::REG_FNUM_HI, {5'b00000, lfo_base[10:8]});
		reg_write(fm_pkg::REG_LFO, 8'h0F);
		wait_sample(2 * `FM_SLOTS);
		reg_write(fm_pkg::REG_KEY, 8'h10);
		lo = 0;
		hi = 0;
		repeat (200) begin
			wait_sample(2 * `FM_SLOTS);
			lo = lo + int'(lfo_base);
			hi = hi + int'(lfo_base) + 127;
			check_range("snd", int'(snd), lo >> 8, hi >> 8);
		end
		assert (int'(snd) > (lo >> 8)) else begin
			$display("LFO never raised the phase step above the base step");
			stop_with_failure();
		end

		$display("TEST PASSED");
		$finish;
	end
endmodule

/* verilog/fm_core.sv */
`timescale 1ns/1ps

module fm_core (
	input  logic        clk_int,
	input  logic        rst,
	input  logic [7:0]  din,
	input  logic [1:0]  addr,
	input  logic        cs_n,
	input  logic        wr_n,
	output logic [7:0]  dout,
	output logic [11:0] snd,
	output logic        sample,
	output logic        irq_n
);
	fm_pkg::reg_addr_e reg_addr;
	logic              data_wr;
	logic [7:0]        wr_data;
	logic              zero;
	logic              lfo_en;
	logic [2:0]        lfo_freq;
	logic              key_on;
	logic [10:0]       fnum;
	logic [2:0]        block;
	logic [6:0]        lfo_mod;

	timer_ctrl_if tmr ();

	host_bus host_bus_inst (
		.clk_int(clk_int), .rst(rst), .din(din), .addr(addr),
		.cs_n(cs_n), .wr_n(wr_n),
		.flag_a(tmr.flag_a), .flag_b(tmr.flag_b),
		.dout(dout), .reg_addr(reg_addr), .data_wr(data_wr), .wr_data(wr_data)
	);

	fm_regs fm_regs_inst (
		.clk_int(clk_int), .rst(rst), .reg_addr(reg_addr),
		.data_wr(data_wr), .wr_data(wr_data), .tmr(tmr.regs),
		.zero(zero), .lfo_en(lfo_en), .lfo_freq(lfo_freq),
		.key_on(key_on), .fnum(fnum), .block(block)
	);

	fm_timers fm_timers_inst (
		.clk_int(clk_int), .rst(rst), .zero(zero), .tmr(tmr.timers), .irq_n(irq_n)
	);

	fm_lfo fm_lfo_inst (
		.clk_int(clk_int), .rst(rst), .zero(zero),
		.lfo_en(lfo_en), .lfo_freq(lfo_freq), .lfo_mod(lfo_mod)
	);

	fm_tone fm_tone_inst (
		.clk_int(clk_int), .rst(rst), .zero(zero), .key_on(key_on),
		.fnum(fnum), .block(block), .lfo_mod(lfo_mod),
		.snd(snd), .sample(sample)
	);
endmodule

/* verilog/fm_tone.sv */
`timescale 1ns/1ps
`include "fm_params.svh"

module fm_tone (
	input  logic        clk_int,
	input  logic        rst,
	input  logic        zero,
	input  logic        key_on,
	input  logic [10:0] fnum,
	input  logic [2:0]  block,
	input  logic [6:0]  lfo_mod,
	output logic [11:0] snd,
	output logic        sample
);
	typedef logic [`FM_PHASE_WIDTH-1:0] phase_t;

	phase_t phase;
	phase_t step;

	// Octave shift then vibrato on top
	assign step = (phase_t'(fnum) << block) + phase_t'(lfo_mod);

	always_ff @(posedge clk_int) begin
		if (rst) begin
			phase  <= '0;
			sample <= 1'b0;
		end else begin
			sample <= zero;
			if (!key_on)
				phase <= '0;
			else if (zero)
				phase <= phase + step;
		end
	end

	// Sawtooth from the top phase bits
	assign snd = phase[`FM_PHASE_WIDTH-1 -: 12];
endmodule

/* verilog/fm_lfo.sv */
`timescale 1ns/1ps

module fm_lfo (
	input  logic       clk_int,
	input  logic       rst,
	input  logic       zero,
	input  logic       lfo_en,
	input  logic [2:0] lfo_freq,
	output logic [6:0] lfo_mod
);
	fm_pkg::lfo_rate_t rate_tbl;
	logic [6:0]        div_cnt;
	logic [7:0]        lfo_cnt;

	// Entry 0 is the slowest rate
	assign rate_tbl = {7'd5, 7'd8, 7'd44, 7'd62, 7'd67, 7'd71, 7'd77, 7'd108};

	always_ff @(posedge clk_int) begin
		if (rst || !lfo_en) begin
			div_cnt <= '0;
			lfo_cnt <= '0;
		end else if (zero) begin
			// Greater-or-equal copes with a rate change mid count
			if (div_cnt >= rate_tbl[lfo_freq] - 1'b1) begin
				div_cnt <= '0;
				lfo_cnt <= lfo_cnt + 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// Triangle folded from the counter MSB
	assign lfo_mod = lfo_en ? (lfo_cnt[7] ? ~lfo_cnt[6:0] : lfo_cnt[6:0]) : 7'd0;
endmodule

/* verilog/fm_timers.sv */
`timescale 1ns/1ps
`include "fm_params.svh"

module fm_timers (
	input  logic         clk_int,
	input  logic         rst,
	input  logic         zero,
	timer_ctrl_if.timers tmr,
	output logic         irq_n
);
	typedef logic [$clog2(`FM_TB_PRESCALE)-1:0] presc_t;

	logic [`FM_TA_WIDTH-1:0] cnt_a;
	logic [`FM_TB_WIDTH-1:0] cnt_b;
	presc_t                  presc;
	logic                    run_a;
	logic                    run_b;
	logic                    tick_b;

	// Timer B advances once every FM_TB_PRESCALE frames
	assign tick_b = zero && presc == presc_t'(`FM_TB_PRESCALE - 1);

	always_ff @(posedge clk_int) begin
		if (rst) begin
			run_a      <= 1'b0;
			cnt_a      <= '0;
			tmr.flag_a <= 1'b0;
		end else begin
			if (tmr.load_a) begin
				run_a <= 1'b1;
				cnt_a <= tmr.value_a;
			end else if (zero && run_a) begin
				if (&cnt_a) begin
					cnt_a <= tmr.value_a;
					if (tmr.irq_en_a)
						tmr.flag_a <= 1'b1;
				end else begin
					cnt_a <= cnt_a + 1'b1;
				end
			end
			if (tmr.clr_flag_a)
				tmr.flag_a <= 1'b0;
		end
	end

	always_ff @(posedge clk_int) begin
		if (rst) begin
			run_b      <= 1'b0;
			cnt_b      <= '0;
			presc      <= '0;
			tmr.flag_b <= 1'b0;
		end else begin
			if (tmr.load_b) begin
				run_b <= 1'b1;
				cnt_b <= tmr.value_b;
				presc <= '0;
			end else if (zero && run_b) begin
				presc <= tick_b ? '0 : presc + 1'b1;
				if (tick_b && &cnt_b) begin
					cnt_b <= tmr.value_b;
					if (tmr.irq_en_b)
						tmr.flag_b <= 1'b1;
				end else if (tick_b) begin
					cnt_b <= cnt_b + 1'b1;
				end
			end
			if (tmr.clr_flag_b)
				tmr.flag_b <= 1'b0;
		end
	end

	assign irq_n = !((tmr.flag_a && tmr.irq_en_a) || (tmr.flag_b && tmr.irq_en_b));
endmodule

/* verilog/fm_regs.sv */
`timescale 1ns/1ps
`include "fm_params.svh"

module fm_regs (
	input  logic              clk_int,
	input  logic              rst,
	input  fm_pkg::reg_addr_e reg_addr,
	input  logic              data_wr,
	input  logic [7:0]        wr_data,
	timer_ctrl_if.regs        tmr,
	output logic              zero,
	output logic              lfo_en,
	output logic [2:0]        lfo_freq,
	output logic              key_on,
	output logic [10:0]       fnum,
	output logic [2:0]        block
);
	typedef logic [$clog2(`FM_SLOTS)-1:0] slot_cnt_t;

	slot_cnt_t slot_cnt;
	logic      last_slot;

	assign last_slot = slot_cnt == slot_cnt_t'(`FM_SLOTS - 1);

	// One zero pulse per slot frame
	always_ff @(posedge clk_int) begin
		if (rst) begin
			slot_cnt <= '0;
			zero     <= 1'b0;
		end else begin
			zero     <= last_slot;
			slot_cnt <= last_slot ? '0 : slot_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_int) begin
		if (rst) begin
			lfo_en         <= 1'b0;
			key_on         <= 1'b0;
			tmr.irq_en_a   <= 1'b0;
			tmr.irq_en_b   <= 1'b0;
			tmr.load_a     <= 1'b0;
			tmr.load_b     <= 1'b0;
			tmr.clr_flag_a <= 1'b0;
			tmr.clr_flag_b <= 1'b0;
		end else begin
			// Timer strobes last a single cycle
			tmr.load_a     <= 1'b0;
			tmr.load_b     <= 1'b0;
			tmr.clr_flag_a <= 1'b0;
			tmr.clr_flag_b <= 1'b0;
			if (data_wr) begin
				case (reg_addr)
					fm_pkg::REG_LFO: lfo_en <= wr_data[3];
					fm_pkg::REG_KEY: key_on <= wr_data[4];
					fm_pkg::REG_TIMER_CTL: begin
						tmr.load_a     <= wr_data[0];
						tmr.load_b     <= wr_data[1];
						tmr.irq_en_a   <= wr_data[2];
						tmr.irq_en_b   <= wr_data[3];
						tmr.clr_flag_a <= wr_data[4];
						tmr.clr_flag_b <= wr_data[5];
					end
					default: ;
				endcase
			end
		end
	end

	// Held values
	always_ff @(posedge clk_int) begin
		if (data_wr) begin
			case (reg_addr)
				fm_pkg::REG_LFO:     lfo_freq <= wr_data[2:0];
				// Timer A splits as 8 high bits and 2 low bits
				fm_pkg::REG_TA_HI:   tmr.value_a[`FM_TA_WIDTH-1:2] <= wr_data;
				fm_pkg::REG_TA_LO:   tmr.value_a[1:0] <= wr_data[1:0];
				fm_pkg::REG_TB:      tmr.value_b <= wr_data;
				fm_pkg::REG_FNUM_LO: fnum[7:0] <= wr_data;
				fm_pkg::REG_FNUM_HI: begin
					fnum[10:8] <= wr_data[2:0];
					block      <= wr_data[5:3];
				end
				default: ;
			endcase
		end
	end
endmodule

/* verilog/host_bus.sv */
`timescale 1ns/1ps
`include "fm_params.svh"

module host_bus (
	input  logic              clk_int,
	input  logic              rst,
	input  logic [7:0]        din,
	input  logic [1:0]        addr,
	input  logic              cs_n,
	input  logic              wr_n,
	input  logic              flag_a,
	input  logic              flag_b,
	output logic [7:0]        dout,
	output fm_pkg::reg_addr_e reg_addr,
	output logic              data_wr,
	output logic [7:0]        wr_data
);
	typedef logic [$clog2(`FM_BUSY_CYCLES + 1)-1:0] busy_cnt_t;

	busy_cnt_t busy_cnt;
	logic      write;
	logic      busy;

	// Ports 2 and 3 belong to the absent second bank
	assign write = !cs_n && !wr_n && !addr[1];
	assign busy = busy_cnt != '0;

	always_ff @(posedge clk_int) begin
		if (rst) begin
			reg_addr <= fm_pkg::REG_LFO;
			data_wr  <= 1'b0;
			busy_cnt <= '0;
		end else begin
			data_wr <= write && addr[0];
			if (write && !addr[0])
				reg_addr <= fm_pkg::reg_addr_e'(din);
			// Every data write restarts the busy window
			if (write && addr[0])
				busy_cnt <= busy_cnt_t'(`FM_BUSY_CYCLES);
			else if (busy)
				busy_cnt <= busy_cnt - 1'b1;
		end
	end

	// Data byte for the register map
	always_ff @(posedge clk_int) begin
		if (write && addr[0])
			wr_data <= din;
	end

	assign dout = {busy, 5'b00000, flag_b, flag_a};
endmodule

/* verilog/timer_ctrl_if.sv */
`timescale 1ns/1ps
`include "fm_params.svh"

interface timer_ctrl_if;
	logic [`FM_TA_WIDTH-1:0] value_a;
	logic [`FM_TB_WIDTH-1:0] value_b;
	// One-cycle strobes from the register map
	logic                    load_a;
	logic                    load_b;
	logic                    clr_flag_a;
	logic                    clr_flag_b;
	// Held interrupt enables
	logic                    irq_en_a;
	logic                    irq_en_b;
	// Sticky overflow flags
	logic                    flag_a;
	logic                    flag_b;

	modport regs (
		output value_a, value_b, load_a, load_b,
		output clr_flag_a, clr_flag_b, irq_en_a, irq_en_b
	);

	modport timers (
		input  value_a, value_b, load_a, load_b,
		input  clr_flag_a, clr_flag_b, irq_en_a, irq_en_b,
		output flag_a, flag_b
	);
endinterface

/* verilog/fm_pkg.sv */
package fm_pkg;

	// Host register addresses decoded by the register map
	typedef enum logic [7:0] {
		REG_LFO       = 8'h22,
		REG_TA_HI     = 8'h24,
		REG_TA_LO     = 8'h25,
		REG_TB        = 8'h26,
		REG_TIMER_CTL = 8'h27,
		REG_KEY       = 8'h28,
		REG_FNUM_LO   = 8'hA0,
		REG_FNUM_HI   = 8'hA4
	} reg_addr_e;

	// Frames per LFO step, one entry per lfo_freq value
	typedef logic [7:0][6:0] lfo_rate_t;

endpackage

/* include/fm_params.svh */
`ifndef FM_PARAMS_SVH
`define FM_PARAMS_SVH

// Clock cycles in one slot frame
`define FM_SLOTS 24

// Cycles that busy stays high after a data write
`define FM_BUSY_CYCLES 32

// Timer counter widths
`define FM_TA_WIDTH 10
`define FM_TB_WIDTH 8

// Frames per timer B count
`define FM_TB_PRESCALE 16

// Phase accumulator width
`define FM_PHASE_WIDTH 20

`endif
